/* control_unit.f */
cu_isa_pkg.sv
cu_ctrl_pkg.sv
routine_decoder.sv
phase_sequencer.sv
control_word_table.sv
control_unit.sv
tb_clock_gen.sv
tb_control_unit.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_control_unit -f control_unit.f \
	-o sim_control_unit || { echo "build failed"; exit 1; }
./obj_dir/sim_control_unit > sim.log 2>&1
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb_control_unit.sv */
module tb_control_unit;
	import cu_isa_pkg::*;
	import cu_ctrl_pkg::*;

	localparam int reset_cycles = 16;
	localparam int idle_cycles = 20;
	localparam int num_programs = 12;
	localparam int instrs_per_program = 10;
	localparam int longest_instr = 13;	// four fetch steps plus the nine LDAC steps
	localparam int program_cycles = 5 + (instrs_per_program + 3) * longest_instr;
	localparam int watchdog_cycles = 2 * (reset_cycles + idle_cycles + num_programs * program_cycles);
	localparam logic [5:0] f_rst = 6'b100000;
	localparam logic [5:0] f_clr = 6'b010000;
	localparam logic [5:0] f_ird = 6'b001000;
	localparam logic [5:0] f_drd = 6'b000010;
	localparam logic [5:0] f_dwr = 6'b000001;

	logic clk, reset, zflag, start, busy, rst_pc, clear_ac;
	logic iram_read, iram_write, dram_read, dram_write;
	logic [instr_w-1:0] instruction;
	mux_sel_t mux_sig, exp_mux;
	load_sel_t load_sig, exp_load;
	inc_sel_t inc_sig, exp_inc;
	alu_op_t alu_sig, exp_alu;
	logic [5:0] exp_flags;	// rst_pc, clear_ac, iram_read, iram_write, dram_read, dram_write
	logic exp_busy;
	phase_t m_phase = ph_idle;
	int m_step = 0;
	routine_t m_routine = rt_halt;
	logic [15:0] lfsr = 16'd43;
	string test_name = "reset";

	tb_clock_gen u_clock (.clk(clk));

	control_unit u_dut (.*);

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	function automatic routine_t decode(input logic [7:0] ins, input logic z);
		logic [3:0] opd;
		opd = ins[3:0];
		case (opcode_t'(ins[7:4]))
			op_nop: return rt_nop;
			op_clac: return rt_clac;
			op_ldac: return (opd == opd_direct) ? rt_ldac : rt_halt;
			op_stac: return (opd == opd_direct) ? rt_stac : rt_halt;
			op_mvr: return (opd == opd_sr) ? rt_mvr_sr : (opd == opd_cdr) ? rt_mvr_cdr :
				(opd == opd_a) ? rt_mvr_a : rt_halt;
			op_mvac:
				case (opd)
					opd_a: return rt_mvac_a;
					opd_b: return rt_mvac_b;
					opd_c: return rt_mvac_c;
					opd_cdr: return rt_mvac_cdr;
					opd_sr: return rt_mvac_sr;
					opd_pr: return rt_mvac_pr;
					opd_r: return rt_mvac_r;
					default: return rt_halt;
				endcase
			op_mul: return rt_mul;
			op_add: return (opd == opd_cdr) ? rt_add_cdr : (opd == opd_sr) ? rt_add_sr : rt_halt;
			op_sub: return (opd == opd_r) ? rt_sub_r : (opd == opd_cdr) ? rt_sub_cdr : rt_halt;
			op_jpnz: return z ? rt_jpnz_not_taken : rt_jpnz_taken;
			op_incac: return rt_incac;
			default: return rt_halt;
		endcase
	endfunction

	function automatic int exec_length(input routine_t rt);
		case (rt)
			rt_ldac: return 9;
			rt_stac: return 7;
			rt_jpnz_taken: return 3;
			default: return 1;
		endcase
	endfunction

	task automatic set_word(input mux_sel_t m, input load_sel_t l, input inc_sel_t i,
		input alu_op_t a, input logic [5:0] f);
		exp_mux = m;
		exp_load = l;
		exp_inc = i;
		exp_alu = a;
		exp_flags = f;
	endtask

	task automatic expected_word();
		logic ld;
		ld = (m_routine == rt_ldac);
		set_word(sel_none, load_off, inc_off, alu_inactive, 6'b0);
		exp_busy = (m_phase != ph_idle);
		if (m_phase == ph_start)
			exp_flags = f_rst;
		else if (m_phase == ph_fetch)
			case (m_step)
				0: exp_flags = f_ird;
				1: set_word(sel_iram, load_dr, inc_off, alu_inactive, 6'b0);
				2: set_word(sel_dr, load_ir, inc_pc, alu_inactive, 6'b0);
				default: exp_flags = 6'b0;	// decode cycle
			endcase
		else if (m_phase == ph_exec && exec_length(m_routine) > 1)
			case (m_step)
				0: exp_flags = f_ird;
				1, 3: set_word(sel_iram, load_dr, inc_off, alu_inactive, 6'b0);
				2:
					if (m_routine == rt_jpnz_taken)
						set_word(sel_dr, load_pc, inc_off, alu_inactive, 6'b0);
					else
						set_word(sel_dr, load_tr, inc_pc, alu_inactive, f_ird);
				4: set_word(sel_drtr, load_ar, inc_pc, alu_inactive, ld ? f_drd : 6'b0);
				5:
					if (ld)
						set_word(sel_dram, load_dr, inc_off, alu_inactive, 6'b0);
					else
						set_word(sel_ac, load_dr, inc_off, alu_inactive, f_dwr);
				6:
					if (ld)
						set_word(sel_dr, load_tr, inc_ar, alu_inactive, f_drd);
					else
						set_word(sel_acinv, load_dr, inc_ar, alu_inactive, f_dwr);
				7: set_word(sel_dram, load_dr, inc_off, alu_inactive, 6'b0);
				default: set_word(sel_drtr, load_ac, inc_off, alu_inactive, 6'b0);
			endcase
		else if (m_phase == ph_exec)
			case (m_routine)
				rt_clac: exp_flags = f_clr;
				rt_mvr_sr: set_word(sel_sr, load_ac, inc_off, alu_inactive, 6'b0);
				rt_mvr_cdr: set_word(sel_cdr, load_ac, inc_off, alu_inactive, 6'b0);
				rt_mvr_a: set_word(sel_a, load_ac, inc_off, alu_inactive, 6'b0);
				rt_mvac_a: set_word(sel_ac, load_a, inc_off, alu_inactive, 6'b0);
				rt_mvac_b: set_word(sel_ac, load_b, inc_off, alu_inactive, 6'b0);
				rt_mvac_c: set_word(sel_ac, load_c, inc_off, alu_inactive, 6'b0);
				rt_mvac_cdr: set_word(sel_ac, load_cdr, inc_off, alu_inactive, 6'b0);
				rt_mvac_sr: set_word(sel_ac, load_sr, inc_off, alu_inactive, 6'b0);
				rt_mvac_pr: set_word(sel_ac, load_pr, inc_off, alu_inactive, 6'b0);
				rt_mvac_r: set_word(sel_ac, load_r, inc_off, alu_inactive, 6'b0);
				rt_mul: set_word(sel_pr, load_off, inc_off, alu_mul, 6'b0);
				rt_add_cdr: set_word(sel_cdr, load_off, inc_off, alu_add, 6'b0);
				rt_add_sr: set_word(sel_sr, load_off, inc_off, alu_add, 6'b0);
				rt_sub_r: set_word(sel_r, load_off, inc_off, alu_sub, 6'b0);
				rt_sub_cdr: set_word(sel_cdr, load_off, inc_off, alu_sub, 6'b0);
				rt_jpnz_not_taken: exp_inc = inc_pc;
				rt_incac: exp_inc = inc_ac;
				rt_halt: exp_busy = 1'b0;	// busy drops in the halt step itself
				default: exp_flags = 6'b0;
			endcase
	endtask

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input string exp, input string act);
		stop_on_failure($sformatf("ERROR %s: %s expected %s actual %s",
			test_name, what, exp, act));
	endtask

	task automatic check_mux(input mux_sel_t exp, input mux_sel_t act);
		if (exp !== act)
			report_mismatch("mux_sig", exp.name(), act.name());
	endtask

	task automatic check_load(input load_sel_t exp, input load_sel_t act);
		if (exp !== act)
			report_mismatch("load_sig", exp.name(), act.name());
	endtask

	task automatic check_inc(input inc_sel_t exp, input inc_sel_t act);
		if (exp !== act)
			report_mismatch("inc_sig", exp.name(), act.name());
	endtask

	task automatic check_alu(input alu_op_t exp, input alu_op_t act);
		if (exp !== act)
			report_mismatch("alu_sig", exp.name(), act.name());
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act)
			report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
	endtask

	task automatic check_outputs();
		expected_word();
		check_mux(exp_mux, mux_sig);
		check_load(exp_load, load_sig);
		check_inc(exp_inc, inc_sig);
		check_alu(exp_alu, alu_sig);
		check_flag("busy", exp_busy, busy);
		check_flag("rst_pc", exp_flags[5], rst_pc);
		check_flag("clear_ac", exp_flags[4], clear_ac);
		check_flag("iram_read", exp_flags[3], iram_read);
		check_flag("iram_write", exp_flags[2], iram_write);
		check_flag("dram_read", exp_flags[1], dram_read);
		check_flag("dram_write", exp_flags[0], dram_write);
	endtask

	// the model moves on with the inputs that the DUT samples at the next edge
	task automatic advance_model(input logic st, input logic [7:0] ins, input logic z);
		phase_t prev;
		prev = m_phase;
		case (m_phase)
			ph_idle: m_phase = st ? ph_start : ph_idle;
			ph_start: m_phase = ph_fetch;
			ph_fetch:
				if (m_step == 3)
				begin
					m_routine = decode(ins, z);
					m_phase = ph_exec;
				end
			default:
				if (m_routine == rt_halt)
					m_phase = ph_idle;
				else if (m_step == exec_length(m_routine) - 1)
					m_phase = ph_fetch;
		endcase
		// the step counts up within fetch or exec and restarts on every phase change
		if (m_phase == prev && (prev == ph_fetch || prev == ph_exec))
			m_step++;
		else
			m_step = 0;
	endtask

	task automatic cycle(input logic st, input logic [7:0] ins, input logic z);
		@(posedge clk);
		start <= st;
		instruction <= ins;
		zflag <= z;
		@(negedge clk);
		check_outputs();
		advance_model(st, ins, z);
	endtask

	// holds one instruction until the unit is back at fetch step 0 or idle
	task automatic run_instruction(input logic [7:0] ins, input logic z);
		logic [7:0] r;
		do
		begin
			rand_bits(1, r);
			cycle(r[0], ins, z);
		end
		while (!((m_phase == ph_fetch && m_step == 0) || m_phase == ph_idle));
	endtask

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		stop_on_failure("watchdog expired before all programs finished");
	end

	initial
	begin
		logic [7:0] r;
		logic [7:0] z;
		reset = 1'b1;
		start = 1'b0;
		instruction = '0;
		zflag = 1'b0;
		for (int i = 0; i < reset_cycles; i++)
		begin
			@(posedge clk);
			rand_bits(8, r);
			instruction <= r;
			reset <= (i < reset_cycles - 1);
		end
		test_name = "idle after reset";
		for (int i = 0; i < idle_cycles; i++)
		begin
			rand_bits(8, r);
			rand_bits(1, z);
			cycle(1'b0, r, z[0]);
		end
		for (int p = 0; p < num_programs; p++)
		begin
			test_name = "start strobe";
			rand_bits(8, r);
			cycle(1'b1, r, 1'b0);
			run_instruction(r, 1'b0);
			test_name = "legal instructions";
			for (int i = 0; i < instrs_per_program; i++)
			begin
				do
					rand_bits(8, r);
				while (decode(r, 1'b0) == rt_halt);
				rand_bits(1, z);
				run_instruction(r, z[0]);
			end
			test_name = "jpnz";
			run_instruction({op_jpnz, 4'h0}, 1'b0);
			run_instruction({op_jpnz, 4'h0}, 1'b1);
			test_name = "program end";
			rand_bits(1, z);
			if (z[0])
			begin
				rand_bits(4, r);
				r = {op_end, r[3:0]};
			end
			else
				do
					rand_bits(8, r);
				while (decode(r, 1'b0) != rt_halt);	// undefined opcode or operand
			run_instruction(r, 1'b0);
			test_name = "idle between programs";
			repeat (3) cycle(1'b0, r, 1'b1);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk
);
	localparam int half_period = 20;

	initial
	begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

endmodule

/* control_unit.sv */
module control_unit (
	input logic clk,
	input logic reset,
	input logic [cu_isa_pkg::instr_w-1:0] instruction,
	input logic zflag,
	input logic start,
	output cu_ctrl_pkg::mux_sel_t mux_sig,
	output cu_ctrl_pkg::load_sel_t load_sig,
	output cu_ctrl_pkg::inc_sel_t inc_sig,
	output cu_ctrl_pkg::alu_op_t alu_sig,
	output logic busy,
	output logic rst_pc,
	output logic clear_ac,
	output logic iram_read,
	output logic iram_write,
	output logic dram_read,
	output logic dram_write
);
	import cu_ctrl_pkg::*;

	phase_t phase;
	step_t step;
	routine_t routine;
	next_act_t next_act;

	// port names match the local nets one to one
	routine_decoder u_decoder (.*);

	phase_sequencer u_sequencer (.*);

	control_word_table u_table (.*);

endmodule

/* control_word_table.sv */
module control_word_table (
	input cu_ctrl_pkg::phase_t phase,
	input cu_ctrl_pkg::step_t step,
	input cu_ctrl_pkg::routine_t routine,
	output cu_ctrl_pkg::mux_sel_t mux_sig,
	output cu_ctrl_pkg::load_sel_t load_sig,
	output cu_ctrl_pkg::inc_sel_t inc_sig,
	output cu_ctrl_pkg::alu_op_t alu_sig,
	output logic rst_pc,
	output logic clear_ac,
	output logic iram_read,
	output logic iram_write,
	output logic dram_read,
	output logic dram_write,
	output cu_ctrl_pkg::next_act_t next_act
);
	import cu_ctrl_pkg::*;

	always_comb
	begin
		mux_sig = sel_none;
		load_sig = load_off;
		inc_sig = inc_off;
		alu_sig = alu_inactive;
		rst_pc = 1'b0;
		clear_ac = 1'b0;
		iram_read = 1'b0;
		iram_write = 1'b0;
		dram_read = 1'b0;
		dram_write = 1'b0;
		next_act = act_step;
		case (phase)
			ph_start: rst_pc = 1'b1;
			ph_fetch:
			begin
				case (step)
					4'd0: iram_read = 1'b1;
					4'd1:
					begin
						mux_sig = sel_iram;
						load_sig = load_dr;
					end
					4'd2:
					begin
						mux_sig = sel_dr;
						load_sig = load_ir;
						inc_sig = inc_pc;
					end
					default: next_act = act_step;
				endcase
				if (step == fetch_last_step)
					next_act = act_to_exec;	// last step is a quiet decode cycle
			end
			ph_exec:
			begin
				next_act = act_to_fetch;	// most routines finish in one step
				case (routine)
					rt_ldac, rt_stac, rt_jpnz_taken:
					begin
						// the first steps read the address byte after the opcode
						case (step)
							4'd0: iram_read = 1'b1;
							4'd1, 4'd3:
							begin
								mux_sig = sel_iram;
								load_sig = load_dr;
							end
							4'd2:
							begin
								mux_sig = sel_dr;
								load_sig = (routine == rt_jpnz_taken) ? load_pc : load_tr;
								inc_sig = (routine == rt_jpnz_taken) ? inc_off : inc_pc;
								iram_read = (routine != rt_jpnz_taken);
							end
							4'd4:
							begin
								mux_sig = sel_drtr;
								load_sig = load_ar;
								inc_sig = inc_pc;
								dram_read = (routine == rt_ldac);
							end
							4'd5:
							begin
								mux_sig = (routine == rt_ldac) ? sel_dram : sel_ac;
								load_sig = load_dr;
								dram_write = (routine == rt_stac);
							end
							4'd6:
							begin
								mux_sig = (routine == rt_ldac) ? sel_dr : sel_acinv;
								load_sig = (routine == rt_ldac) ? load_tr : load_dr;
								inc_sig = inc_ar;
								dram_read = (routine == rt_ldac);
								dram_write = (routine == rt_stac);
							end
							4'd7:
							begin
								mux_sig = sel_dram;
								load_sig = load_dr;
							end
							default:
							begin
								mux_sig = sel_drtr;	// second data byte joins the first in AC
								load_sig = load_ac;
							end
						endcase
						if ((routine == rt_ldac && step != 4'd8) ||
							(routine == rt_stac && step != 4'd6) ||
							(routine == rt_jpnz_taken && step != 4'd2))
							next_act = act_step;
					end
					rt_clac: clear_ac = 1'b1;
					rt_jpnz_not_taken: inc_sig = inc_pc;	// skip the unused target byte
					rt_incac: inc_sig = inc_ac;
					rt_halt: next_act = act_to_idle;
					default:
					begin
						case (routine)
							rt_mvr_sr, rt_add_sr: mux_sig = sel_sr;
							rt_mvr_cdr, rt_add_cdr, rt_sub_cdr: mux_sig = sel_cdr;
							rt_mvr_a: mux_sig = sel_a;
							rt_mul: mux_sig = sel_pr;
							rt_sub_r: mux_sig = sel_r;
							rt_nop: mux_sig = sel_none;
							default: mux_sig = sel_ac;	// every MVAC drives AC onto the bus
						endcase
						case (routine)
							rt_mvr_sr, rt_mvr_cdr, rt_mvr_a: load_sig = load_ac;
							rt_mvac_a: load_sig = load_a;
							rt_mvac_b: load_sig = load_b;
							rt_mvac_c: load_sig = load_c;
							rt_mvac_cdr: load_sig = load_cdr;
							rt_mvac_sr: load_sig = load_sr;
							rt_mvac_pr: load_sig = load_pr;
							rt_mvac_r: load_sig = load_r;
							default: load_sig = load_off;
						endcase
						case (routine)
							rt_mul: alu_sig = alu_mul;
							rt_add_sr, rt_add_cdr: alu_sig = alu_add;
							rt_sub_r, rt_sub_cdr: alu_sig = alu_sub;
							default: alu_sig = alu_inactive;
						endcase
					end
				endcase
			end
			default: next_act = act_step;
		endcase
	end

endmodule

/* phase_sequencer.sv */
module phase_sequencer (
	input logic clk,
	input logic reset,
	input logic start,
	input cu_ctrl_pkg::next_act_t next_act,
	output cu_ctrl_pkg::phase_t phase,
	output cu_ctrl_pkg::step_t step,
	output logic busy
);
	import cu_ctrl_pkg::*;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= ph_idle;
			step <= '0;
		end
		else
		begin
			case (phase)
				ph_idle:
					if (start)
						phase <= ph_start;	// strobes outside idle are simply dropped
				ph_start:
				begin
					phase <= ph_fetch;
					step <= '0;
				end
				default:
				begin
					if (next_act == act_step)
						step <= step + 4'd1;
					else
						step <= '0;
					case (next_act)
						act_to_exec: phase <= ph_exec;
						act_to_fetch: phase <= ph_fetch;
						act_to_idle: phase <= ph_idle;
						default: phase <= phase;
					endcase
				end
			endcase
		end
	end

	// busy already falls in the halt step, one cycle before idle
	assign busy = (phase != ph_idle) && (next_act != act_to_idle);

endmodule

/* routine_decoder.sv */
module routine_decoder (
	input logic clk,
	input logic reset,
	input logic [cu_isa_pkg::instr_w-1:0] instruction,
	input logic zflag,
	input cu_ctrl_pkg::phase_t phase,
	input cu_ctrl_pkg::step_t step,
	output cu_ctrl_pkg::routine_t routine
);
	import cu_isa_pkg::*;
	import cu_ctrl_pkg::*;

	opcode_t opcode;
	operand_t operand;
	routine_t decoded;

	assign opcode = opcode_t'(instruction[instr_w-1 -: opcode_w]);
	assign operand = operand_t'(instruction[operand_w-1:0]);

	always_comb
	begin
		decoded = rt_halt;	// any pair not listed below stops the program
		case (opcode)
			op_nop: decoded = rt_nop;
			op_clac: decoded = rt_clac;
			op_ldac:
				if (operand == opd_direct)
					decoded = rt_ldac;
			op_stac:
				if (operand == opd_direct)
					decoded = rt_stac;
			op_mvr:
				case (operand)
					opd_sr: decoded = rt_mvr_sr;
					opd_cdr: decoded = rt_mvr_cdr;
					opd_a: decoded = rt_mvr_a;
					default: decoded = rt_halt;
				endcase
			op_mvac:
				case (operand)
					opd_a: decoded = rt_mvac_a;
					opd_b: decoded = rt_mvac_b;
					opd_c: decoded = rt_mvac_c;
					opd_cdr: decoded = rt_mvac_cdr;
					opd_sr: decoded = rt_mvac_sr;
					opd_pr: decoded = rt_mvac_pr;
					opd_r: decoded = rt_mvac_r;
					default: decoded = rt_halt;
				endcase
			op_mul: decoded = rt_mul;
			op_add:
				case (operand)
					opd_cdr: decoded = rt_add_cdr;
					opd_sr: decoded = rt_add_sr;
					default: decoded = rt_halt;
				endcase
			op_sub:
				case (operand)
					opd_r: decoded = rt_sub_r;
					opd_cdr: decoded = rt_sub_cdr;
					default: decoded = rt_halt;
				endcase
			op_jpnz: decoded = zflag ? rt_jpnz_not_taken : rt_jpnz_taken;	// jump while nonzero
			op_incac: decoded = rt_incac;
			op_end: decoded = rt_halt;
			default: decoded = rt_halt;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			routine <= rt_halt;
		else if (phase == ph_fetch && step == fetch_last_step)
			routine <= decoded;	// IR is loaded by now, so dispatch here
	end

endmodule

/* cu_ctrl_pkg.sv */
package cu_ctrl_pkg;

	typedef enum logic [3:0] {
		sel_dr = 4'b0000,
		sel_pr = 4'b0001,
		sel_sr = 4'b0010,
		sel_cdr = 4'b0011,
		sel_r = 4'b0100,
		sel_tr = 4'b0101,
		sel_a = 4'b0110,
		sel_b = 4'b0111,
		sel_c = 4'b1000,
		sel_ac = 4'b1001,
		sel_dram = 4'b1010,
		sel_iram = 4'b1011,
		sel_drtr = 4'b1100,	// DR and TR together form a full address
		sel_acinv = 4'b1101,
		sel_none = 4'b1111
	} mux_sel_t;

	typedef enum logic [3:0] {
		load_off, load_pc, load_ir, load_ar, load_dr, load_pr, load_sr,
		load_cdr, load_r, load_tr, load_a, load_b, load_c, load_ac
	} load_sel_t;

	// codes 3 to 5 stay reserved for the A, B and C increments
	typedef enum logic [2:0] {
		inc_off = 3'b000,
		inc_pc = 3'b001,
		inc_r = 3'b010,
		inc_ac = 3'b110,
		inc_ar = 3'b111
	} inc_sel_t;

	typedef enum logic [1:0] {
		alu_inactive = 2'b00,
		alu_mul = 2'b01,
		alu_add = 2'b10,
		alu_sub = 2'b11
	} alu_op_t;

	typedef enum logic [4:0] {
		rt_nop, rt_clac, rt_ldac, rt_stac,
		rt_mvr_sr, rt_mvr_cdr, rt_mvr_a,
		rt_mvac_a, rt_mvac_b, rt_mvac_c, rt_mvac_cdr, rt_mvac_sr, rt_mvac_pr, rt_mvac_r,
		rt_mul, rt_add_cdr, rt_add_sr, rt_sub_r, rt_sub_cdr,
		rt_jpnz_taken, rt_jpnz_not_taken, rt_incac, rt_halt
	} routine_t;

	typedef enum logic [1:0] {ph_idle, ph_start, ph_fetch, ph_exec} phase_t;

	typedef logic [3:0] step_t;

	typedef enum logic [1:0] {act_step, act_to_exec, act_to_fetch, act_to_idle} next_act_t;

	localparam step_t fetch_last_step = 4'd3;

endpackage

/* cu_isa_pkg.sv */
package cu_isa_pkg;

	localparam int opcode_w = 4;
	localparam int operand_w = 4;
	localparam int instr_w = opcode_w + operand_w;	// opcode in the upper nibble

	typedef enum logic [opcode_w-1:0] {
		op_nop = 4'b0000,
		op_clac = 4'b0001,
		op_ldac = 4'b0010,
		op_stac = 4'b0011,
		op_mvr = 4'b0100,
		op_mvac = 4'b0101,
		op_mul = 4'b0110,
		op_add = 4'b0111,
		op_sub = 4'b1000,
		op_jpnz = 4'b1001,
		op_incac = 4'b1010,
		op_end = 4'b1111
	} opcode_t;

	// direct addressing shares code 0 with the register operands below
	typedef enum logic [operand_w-1:0] {
		opd_direct = 4'b0000,
		opd_a = 4'b0001,
		opd_b = 4'b0010,
		opd_c = 4'b0011,
		opd_sr = 4'b0100,
		opd_cdr = 4'b0101,
		opd_pr = 4'b0110,
		opd_r = 4'b0111
	} operand_t;

endpackage
